// File: flist.f
hw/spm_pkg.sv
hw/spm_access_if.sv
hw/spm_access_ctrl.sv
hw/spm_wr_steer.sv
hw/spm_lane_ram.sv
hw/spm_rd_steer.sv
hw/spm_top.sv
tests/tb_spm_top.sv

// File: hw/spm_access_ctrl.sv
`timescale 1ns/100ps

module spm_access_ctrl #(
    parameter int DEPTH_WORDS = 2048
) (
    input  logic           clk,
    input  logic           i_rst,
    input  logic           i_enable,
    input  logic           i_wr_en,
    input  spm_pkg::addr_t i_addr,
    input  spm_pkg::be_t   i_be,
    output logic           o_ready,
    output logic           o_bus_err,
    spm_access_if.ctrl     acc
);
    import spm_pkg::*;

    localparam int IDX_W = $clog2(DEPTH_WORDS);

    sess_state_e state_q;
    sess_state_e state_d;
    offset_t     offset_q;
    offset_t     step;
    addr_t       eff_addr;
    lane_t       lane;
    size_t       size;
    logic        be_bad;
    logic        misalign;
    logic        accept;
    logic        legal;
    logic        rd_issue;
    logic        rd_pending_q;
    lane_t       rd_lane_q;
    size_t       rd_size_q;

    assign eff_addr = i_addr + addr_t'(offset_q);
    assign lane     = eff_addr[1:0];

    // Byte-enable code gives both the size and the offset step
    always_comb begin
        be_bad = 1'b0;
        size   = SIZE_BYTE;
        step   = offset_t'(1);
        case (i_be)
            BE_WORD: begin
                size = SIZE_WORD;
                step = offset_t'(4);
            end
            BE_HALF: begin
                size = SIZE_HALF;
                step = offset_t'(2);
            end
            BE_BYTE: begin
                size = SIZE_BYTE;
                step = offset_t'(1);
            end
            default: begin
                be_bad = 1'b1;
            end
        endcase
    end

    // Words must sit on lane 0, halves on an even lane
    assign misalign = ((size == SIZE_WORD) && (lane != 2'd0)) ||
                      ((size == SIZE_HALF) && lane[0]);

    assign accept   = i_enable && (state_q != S_ERROR);
    assign legal    = accept && !be_bad && !misalign;
    assign rd_issue = legal && !i_wr_en;

    always_comb begin
        state_d = state_q;
        if (!i_enable) begin
            state_d = S_IDLE;
        end else if (state_q != S_ERROR) begin
            if (!legal) begin
                state_d = S_ERROR;
            end else if (!i_wr_en) begin
                state_d = S_STREAM;
            end else if (state_q == S_IDLE) begin
                state_d = S_FIRST;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state_q      <= S_IDLE;
            offset_q     <= '0;
            rd_pending_q <= 1'b0;
        end else begin
            state_q      <= state_d;
            rd_pending_q <= rd_issue;
            if (!i_enable) begin
                offset_q <= '0;
            end else if (legal) begin
                offset_q <= offset_q + step;
            end
        end
    end

    // Lane and size of a read follow it to the output mux
    always_ff @(posedge clk) begin
        if (rd_issue) begin
            rd_lane_q <= lane;
            rd_size_q <= size;
        end
    end

    assign o_bus_err = (state_q == S_ERROR);
    assign o_ready   = i_enable && ((state_q == S_STREAM) || (state_q == S_ERROR));

    assign acc.word_idx  = eff_addr[IDX_W+1:2];
    assign acc.lane      = lane;
    assign acc.size      = size;
    assign acc.wr_stb    = legal && i_wr_en;
    assign acc.rd_lane   = rd_lane_q;
    assign acc.rd_size   = rd_size_q;
    // Read data is dropped as soon as the host ends the session
    assign acc.rd_active = rd_pending_q && i_enable;

endmodule

// File: hw/spm_access_if.sv
`timescale 1ns/100ps

interface spm_access_if #(
    parameter int DEPTH_WORDS = 2048
) ();
    import spm_pkg::*;

    localparam int IDX_W = $clog2(DEPTH_WORDS);

    // Access issued in this cycle
    logic [IDX_W-1:0] word_idx;
    lane_t            lane;
    size_t            size;
    logic             wr_stb;

    // Read issued in the previous cycle and lined up with the RAM output word
    lane_t            rd_lane;
    size_t            rd_size;
    logic             rd_active;

    modport ctrl (
        output word_idx,
        output lane,
        output size,
        output wr_stb,
        output rd_lane,
        output rd_size,
        output rd_active
    );

    modport wr_path (
        input lane,
        input size,
        input wr_stb
    );

    modport ram (
        input word_idx
    );

    modport rd_path (
        input rd_lane,
        input rd_size,
        input rd_active
    );

endinterface

// File: hw/spm_lane_ram.sv
`timescale 1ns/100ps

module spm_lane_ram #(
    parameter int DEPTH_WORDS = 2048
) (
    input  logic           clk,
    spm_access_if.ram      acc,
    input  spm_pkg::be_t   i_lane_we,
    input  spm_pkg::data_t i_lane_wdata,
    output spm_pkg::data_t o_rdata_word
);
    import spm_pkg::*;

    data_t rdata_q;

    // One byte-wide array per lane, all addressed by the same word index
    for (genvar g = 0; g < 4; g++) begin : g_lane
        logic [7:0] mem [DEPTH_WORDS];

        always_ff @(posedge clk) begin
            if (i_lane_we[g]) begin
                mem[acc.word_idx] <= i_lane_wdata[g*8 +: 8];
            end
            // Read-before-write on the same word
            rdata_q[g*8 +: 8] <= mem[acc.word_idx];
        end
    end

    assign o_rdata_word = rdata_q;

endmodule

// File: hw/spm_pkg.sv
package spm_pkg;

    // Widths that carry a meaning on the access port
    typedef logic [31:0] data_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  be_t;
    typedef logic [1:0]  lane_t;
    typedef logic [1:0]  size_t;

    // Auto-increment offset added to the host base address
    typedef logic [7:0]  offset_t;

    // Access size codes
    localparam size_t SIZE_BYTE = 2'd0;
    localparam size_t SIZE_HALF = 2'd1;
    localparam size_t SIZE_WORD = 2'd2;

    // Legal byte-enable codes for right-aligned data on the port
    localparam be_t BE_BYTE = 4'b0001;
    localparam be_t BE_HALF = 4'b0011;
    localparam be_t BE_WORD = 4'b1111;

    // Session FSM
    // S_IDLE   no session, or first cycle of a new one
    // S_FIRST  session open, no read accepted yet
    // S_STREAM at least one read accepted in this session
    // S_ERROR  sticky bus error until enable drops
    typedef enum logic [1:0] {
        S_IDLE,
        S_FIRST,
        S_STREAM,
        S_ERROR
    } sess_state_e;

endpackage

// File: hw/spm_rd_steer.sv
`timescale 1ns/100ps

module spm_rd_steer (
    spm_access_if.rd_path  acc,
    input  spm_pkg::data_t i_rdata_word,
    output spm_pkg::data_t o_rdata
);
    import spm_pkg::*;

    data_t aligned;

    // Shift the addressed part down to bit 0, upper bits zero
    always_comb begin
        aligned = '0;
        case (acc.rd_size)
            SIZE_WORD: begin
                aligned = i_rdata_word;
            end
            SIZE_HALF: begin
                if (acc.rd_lane[1]) begin
                    aligned = {16'h0000, i_rdata_word[31:16]};
                end else begin
                    aligned = {16'h0000, i_rdata_word[15:0]};
                end
            end
            SIZE_BYTE: begin
                aligned = {24'h000000, i_rdata_word[acc.rd_lane*8 +: 8]};
            end
            default: begin
                aligned = '0;
            end
        endcase
    end

    assign o_rdata = acc.rd_active ? aligned : '0;

endmodule

// File: hw/spm_top.sv
`timescale 1ns/100ps

module spm_top #(
    parameter int DEPTH_WORDS = 2048
) (
    input  logic           clk,
    input  logic           i_rst,
    input  logic           i_enable,
    input  logic           i_wr_en,
    input  spm_pkg::addr_t i_addr,
    input  spm_pkg::be_t   i_be,
    input  spm_pkg::data_t i_wdata,
    output spm_pkg::data_t o_rdata,
    output logic           o_ready,
    output logic           o_bus_err
);
    import spm_pkg::*;

    // Lane bus into the RAM and raw word out of it
    be_t   lane_we;
    data_t lane_wdata;
    data_t ram_word;

    spm_access_if #(
        .DEPTH_WORDS (DEPTH_WORDS)
    ) acc_if ();

    spm_access_ctrl #(
        .DEPTH_WORDS (DEPTH_WORDS)
    ) u_ctrl (
        .clk       (clk),
        .i_rst     (i_rst),
        .i_enable  (i_enable),
        .i_wr_en   (i_wr_en),
        .i_addr    (i_addr),
        .i_be      (i_be),
        .o_ready   (o_ready),
        .o_bus_err (o_bus_err),
        .acc       (acc_if.ctrl)
    );

    spm_wr_steer u_wr_steer (
        .acc          (acc_if.wr_path),
        .i_wdata      (i_wdata),
        .o_lane_we    (lane_we),
        .o_lane_wdata (lane_wdata)
    );

    spm_lane_ram #(
        .DEPTH_WORDS (DEPTH_WORDS)
    ) u_ram (
        .clk          (clk),
        .acc          (acc_if.ram),
        .i_lane_we    (lane_we),
        .i_lane_wdata (lane_wdata),
        .o_rdata_word (ram_word)
    );

    spm_rd_steer u_rd_steer (
        .acc          (acc_if.rd_path),
        .i_rdata_word (ram_word),
        .o_rdata      (o_rdata)
    );

endmodule

// File: hw/spm_wr_steer.sv
`timescale 1ns/100ps

module spm_wr_steer (
    spm_access_if.wr_path  acc,
    input  spm_pkg::data_t i_wdata,
    output spm_pkg::be_t   o_lane_we,
    output spm_pkg::data_t o_lane_wdata
);
    import spm_pkg::*;

    be_t   lane_mask;
    data_t lane_data;

    // Sub-word data is replicated so that every lane already holds it
    // and the enables pick the lanes that are written
    always_comb begin
        lane_mask = '0;
        lane_data = i_wdata;
        case (acc.size)
            SIZE_WORD: begin
                lane_mask = 4'b1111;
                lane_data = i_wdata;
            end
            SIZE_HALF: begin
                lane_data = {2{i_wdata[15:0]}};
                if (acc.lane[1]) begin
                    lane_mask = 4'b1100;
                end else begin
                    lane_mask = 4'b0011;
                end
            end
            SIZE_BYTE: begin
                lane_mask = be_t'(4'b0001 << acc.lane);
                lane_data = {4{i_wdata[7:0]}};
            end
            default: begin
                lane_mask = '0;
            end
        endcase
    end

    assign o_lane_we    = acc.wr_stb ? lane_mask : '0;
    assign o_lane_wdata = lane_data;

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the scratchpad testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_spm_top --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_spm_top)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation executable returned an error status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation finished: PASS"; then
    exit 0
fi
echo "Testbench did not report success"
exit 1

// File: tests/spm_golden.txt
# tag en wr addr be wdata check | expected: rdata ready bus_err (hex fields)
# One line per clock, inputs applied after the edge, outputs checked before the next
idle         0 0 00000000 0 00000000 1 00000000 0 0
idle         0 1 00000100 f deadbeef 1 00000000 0 0
idle         0 0 00000104 1 00000000 1 00000000 0 0
word_stream  1 1 00000100 f 11223344 1 00000000 0 0
word_stream  1 1 00000100 f 55667788 1 00000000 0 0
word_stream  1 1 00000100 f 99aabbcc 1 00000000 0 0
word_stream  1 1 00000100 f ddeeff00 1 00000000 0 0
word_stream  0 0 00000000 0 00000000 1 00000000 0 0
word_stream  1 0 00000100 f 00000000 1 00000000 0 0
word_stream  1 0 00000100 f 00000000 1 11223344 1 0
word_stream  1 0 00000100 f 00000000 1 55667788 1 0
word_stream  1 0 00000100 f 00000000 1 99aabbcc 1 0
word_stream  1 0 00000100 f 00000000 1 ddeeff00 1 0
word_stream  0 0 00000000 0 00000000 1 00000000 0 0
subword      1 1 00000200 1 ffffffa1 1 00000000 0 0
subword      1 1 00000200 1 eeeeeeb2 1 00000000 0 0
subword      1 1 00000200 1 ddddddc3 1 00000000 0 0
subword      1 1 00000200 1 ccccccd4 1 00000000 0 0
subword      0 0 00000000 0 00000000 1 00000000 0 0
subword      1 0 00000200 3 00000000 1 00000000 0 0
subword      1 0 00000200 3 00000000 1 0000b2a1 1 0
subword      1 0 00000200 3 00000000 1 0000d4c3 1 0
subword      0 0 00000000 0 00000000 1 00000000 0 0
subword      1 0 00000200 f 00000000 1 00000000 0 0
subword      1 0 00000200 f 00000000 1 d4c3b2a1 1 0
subword      0 0 00000000 0 00000000 1 00000000 0 0
subword      1 0 00000200 1 00000000 1 00000000 0 0
subword      1 0 00000200 1 00000000 1 000000a1 1 0
subword      1 0 00000200 3 00000000 1 000000b2 1 0
subword      1 0 00000200 1 00000000 1 0000d4c3 1 0
subword      0 0 00000000 0 00000000 1 00000000 0 0
ready_timing 1 0 00000100 f 00000000 1 00000000 0 0
ready_timing 1 1 00000100 f 0badf00d 1 11223344 1 0
ready_timing 1 1 00000100 f 12345678 1 00000000 1 0
ready_timing 0 0 00000000 0 00000000 1 00000000 0 0
ready_timing 1 0 00000104 f 00000000 1 00000000 0 0
ready_timing 1 0 00000104 f 00000000 1 0badf00d 1 0
ready_timing 1 0 00000104 f 00000000 1 12345678 1 0
ready_timing 0 0 00000000 0 00000000 1 00000000 0 0
misalign     1 1 00000102 f 99999999 1 00000000 0 0
misalign     1 1 00000102 f 88888888 1 00000000 1 1
misalign     1 1 00000100 f 77777777 1 00000000 1 1
misalign     1 1 00000100 1 00000066 1 00000000 1 1
misalign     0 0 00000000 0 00000000 1 00000000 0 1
misalign     0 0 00000000 0 00000000 1 00000000 0 0
misalign     1 0 00000100 f 00000000 1 00000000 0 0
misalign     1 0 00000100 f 00000000 1 11223344 1 0
misalign     0 0 00000000 0 00000000 1 00000000 0 0
bad_be       1 0 00000200 6 00000000 1 00000000 0 0
bad_be       1 0 00000200 f 00000000 1 00000000 1 1
bad_be       1 1 00000200 f 5a5a5a5a 1 00000000 1 1
bad_be       0 0 00000000 0 00000000 1 00000000 0 1
bad_be       0 0 00000000 0 00000000 1 00000000 0 0
bad_be       1 0 00000200 f 00000000 1 00000000 0 0
bad_be       1 0 00000200 f 00000000 1 d4c3b2a1 1 0
bad_be       0 0 00000000 0 00000000 1 00000000 0 0

// File: tests/tb_spm_top.sv
`timescale 1ns/100ps

module tb_spm_top;

    localparam int CLK_PERIOD  = 4;
    localparam int RST_CYCLES  = 16;
    localparam int WAIT_LIMIT  = 100;
    localparam int MAX_LINES   = 500;
    localparam string VEC_FILE = "tests/spm_golden.txt";

    // Seed for $random stimulus
    int seed = 32691;

    logic        clk;
    logic        i_rst;
    logic        i_enable;
    logic        i_wr_en;
    logic [31:0] i_addr;
    logic [3:0]  i_be;
    logic [31:0] i_wdata;
    logic [31:0] o_rdata;
    logic        o_ready;
    logic        o_bus_err;

    string cur_test;
    int    line_no;
    int    test_errs;
    int    tests_passed;
    int    tests_failed;
    logic  run_failed;

    spm_top #(
        .DEPTH_WORDS (2048)
    ) u_dut (
        .clk       (clk),
        .i_rst     (i_rst),
        .i_enable  (i_enable),
        .i_wr_en   (i_wr_en),
        .i_addr    (i_addr),
        .i_be      (i_be),
        .i_wdata   (i_wdata),
        .o_rdata   (o_rdata),
        .o_ready   (o_ready),
        .o_bus_err (o_bus_err)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            $display("[FAIL] %s line %0d %s: expected 0x%08h, actual 0x%08h",
                     cur_test, line_no, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic apply_reset();
        int cycles;
        cycles = 0;
        i_rst = 1'b1;
        for (int i = 0; i < RST_CYCLES; i++) begin
            @(posedge clk);
        end
        #0.5;
        i_rst = 1'b0;
        // Outputs must be quiet before the first vector
        while ((o_ready !== 1'b0 || o_bus_err !== 1'b0) && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (cycles >= WAIT_LIMIT) begin
            $display("Timeout: DUT outputs did not clear after reset");
            run_failed = 1'b1;
        end
    endtask

    task automatic close_test();
        if (test_errs == 0) begin
            $display("Test %s: passed", cur_test);
            tests_passed++;
        end else begin
            $display("Test %s: failed with %0d mismatches", cur_test, test_errs);
            tests_failed++;
        end
    endtask

    // One vector line is one clock cycle
    task automatic run_line(input string text);
        string       tag;
        logic        v_en;
        logic        v_wr;
        logic [31:0] v_addr;
        logic [3:0]  v_be;
        logic [31:0] v_wdata;
        logic        v_chk;
        logic [31:0] v_rdata;
        logic        v_ready;
        logic        v_err;
        int          n;
        n = $sscanf(text, "%s %h %h %h %h %h %h %h %h %h", tag, v_en, v_wr, v_addr,
                    v_be, v_wdata, v_chk, v_rdata, v_ready, v_err);
        if (n != 10) begin
            $display("Golden file line %0d could not be parsed", line_no);
            run_failed = 1'b1;
        end else begin
            if (tag != cur_test) begin
                if (cur_test != "") begin
                    close_test();
                end
                cur_test  = tag;
                test_errs = 0;
            end
            @(posedge clk);
            #0.5;
            i_enable = v_en;
            i_wr_en  = v_wr;
            i_addr   = v_addr;
            i_be     = v_be;
            i_wdata  = v_wdata;
            // Half a nanosecond before the next edge
            #(CLK_PERIOD - 1);
            if (v_chk) begin
                check_value("o_rdata", v_rdata, o_rdata);
                check_value("o_ready", 32'(v_ready), 32'(o_ready));
                check_value("o_bus_err", 32'(v_err), 32'(o_bus_err));
            end
        end
    endtask

    task automatic replay_file(input int fd);
        string text;
        int    code;
        logic  done;
        done = 1'b0;
        while (!done) begin
            code = $fgets(text, fd);
            if (code == 0) begin
                done = 1'b1;
            end else if (line_no >= MAX_LINES) begin
                $display("Timeout: golden file is longer than %0d lines", MAX_LINES);
                run_failed = 1'b1;
                done       = 1'b1;
            end else begin
                line_no++;
                if (text.len() >= 3 && text[0] != "#") begin
                    run_line(text);
                end
            end
        end
    endtask

    initial begin
        int fd;
        clk          = 1'b0;
        i_rst        = 1'b1;
        i_enable     = 1'b0;
        i_wr_en      = 1'b0;
        i_addr       = '0;
        i_be         = '0;
        i_wdata      = '0;
        cur_test     = "";
        line_no      = 0;
        test_errs    = 0;
        tests_passed = 0;
        tests_failed = 0;
        run_failed   = 1'b0;

        apply_reset();
        if (!run_failed) begin
            fd = $fopen(VEC_FILE, "r");
            if (fd == 0) begin
                $display("Could not open golden file %s", VEC_FILE);
                run_failed = 1'b1;
            end else begin
                replay_file(fd);
                $fclose(fd);
            end
        end
        if (cur_test != "") begin
            close_test();
        end

        $display("Summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (!run_failed && tests_failed == 0 && tests_passed > 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
